// ==== qos_mem_defines.svh ====
/*
 * Sizing macros for the QoS memory wrapper: port and level counts,
 * buffer depths and datapath widths. Include wherever a size is needed.
 */
`ifndef QOS_MEM_DEFINES_SVH
`define QOS_MEM_DEFINES_SVH

// Request ports and QoS levels
`define QM_NUM_PORTS   2
`define QM_NUM_LEVELS  4

// Entries per level FIFO and outstanding grants in the tracker
`define QM_QUEUE_DEPTH 4
`define QM_TRACK_DEPTH 4

// Datapath and counter widths
`define QM_ADDR_W      16
`define QM_DATA_W      32
`define QM_CNT_W       16

`endif

// ==== qos_mem_cfg_pkg.sv ====
/*
 * QoS configuration types: the level carried by each request and the
 * arbitration policy selected at the top level.
 */
`include "qos_mem_defines.svh"

package qos_mem_cfg_pkg;

    // ----------------------------------------
    // QoS level
    // ----------------------------------------

    // Highest value is the most urgent
    typedef logic [$clog2(`QM_NUM_LEVELS)-1:0] qos_level_t;

    // ----------------------------------------
    // Arbiter policy
    // ----------------------------------------

    typedef enum logic {
        ARB_STRICT_PRIO = 1'b0,
        ARB_ROUND_ROBIN = 1'b1
    } arb_policy_e;

endpackage

// ==== qos_mem_bus_pkg.sv ====
/*
 * Memory transfer types: the request payload that moves from the ports
 * through the level FIFOs to the memory, and the source port index.
 */
`include "qos_mem_defines.svh"

package qos_mem_bus_pkg;

    // ----------------------------------------
    // Request payload
    // ----------------------------------------

    // 1 + ADDR_W + DATA_W bits
    typedef struct packed {
        logic                  write;
        logic [`QM_ADDR_W-1:0] addr;
        logic [`QM_DATA_W-1:0] wdata;
    } mem_req_t;

    // ----------------------------------------
    // Source port
    // ----------------------------------------

    typedef logic [$clog2(`QM_NUM_PORTS)-1:0] port_idx_t;

endpackage

// ==== qos_head_if.sv ====
/*
 * Head view of the per-level request FIFOs. The queue side shows every
 * level's head; the arbiter side answers with a single pop command.
 */
`include "qos_mem_defines.svh"

interface qos_head_if;

    // One entry per level, driven by the queues
    logic [`QM_NUM_LEVELS-1:0]                        not_empty;
    qos_mem_bus_pkg::mem_req_t  [`QM_NUM_LEVELS-1:0]  head_req;
    qos_mem_bus_pkg::port_idx_t [`QM_NUM_LEVELS-1:0]  head_port;

    // Pop of one level head, driven by the arbiter
    logic                                             pop;
    qos_mem_cfg_pkg::qos_level_t                      pop_level;

    modport queue (
        output not_empty, head_req, head_port,
        input  pop, pop_level
    );

    modport arbiter (
        input  not_empty, head_req, head_port,
        output pop, pop_level
    );

endinterface

// ==== qos_level_queues.sv ====
/*
 * Input side of the wrapper. Admits port requests with lower port index
 * winning a same-level collision, and keeps one circular FIFO per level.
 */
`include "qos_mem_defines.svh"

module qos_level_queues (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  logic [`QM_NUM_PORTS-1:0]                        req_valid_i,
    output logic [`QM_NUM_PORTS-1:0]                        req_ready_o,
    input  qos_mem_bus_pkg::mem_req_t   [`QM_NUM_PORTS-1:0] req_i,
    input  qos_mem_cfg_pkg::qos_level_t [`QM_NUM_PORTS-1:0] req_qos_i,
    qos_head_if.queue                                       head
);

    localparam int NL    = `QM_NUM_LEVELS;
    localparam int NP    = `QM_NUM_PORTS;
    localparam int DEPTH = `QM_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    qos_mem_bus_pkg::mem_req_t  q_req  [NL][DEPTH];
    qos_mem_bus_pkg::port_idx_t q_port [NL][DEPTH];

    logic [PTR_W-1:0] wr_ptr [NL];
    logic [PTR_W-1:0] rd_ptr [NL];
    logic [CNT_W-1:0] count  [NL];

    logic [NL-1:0]              level_free;
    logic [NL-1:0]              push_en;
    logic [NL-1:0]              pop_en;
    qos_mem_bus_pkg::port_idx_t push_src [NL];

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ----------------------------------------
    // Admission
    // ----------------------------------------

    always_comb begin
        for (int l = 0; l < NL; l++) begin
            level_free[l] = (count[l] != CNT_W'(DEPTH));
            pop_en[l]     = head.pop && (head.pop_level == qos_mem_cfg_pkg::qos_level_t'(l));
        end
    end

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            req_ready_o[p] = req_valid_i[p] && level_free[req_qos_i[p]];
            // A lower port asking for the same level takes the slot
            for (int q = 0; q < p; q++) begin
                if (req_valid_i[q] && (req_qos_i[q] == req_qos_i[p])) begin
                    req_ready_o[p] = 1'b0;
                end
            end
        end
    end

    // At most one port per level, so the order of the loop does not matter
    always_comb begin
        push_en = '0;
        for (int l = 0; l < NL; l++) begin
            push_src[l] = '0;
        end
        for (int p = 0; p < NP; p++) begin
            if (req_ready_o[p]) begin
                push_en[req_qos_i[p]]  = 1'b1;
                push_src[req_qos_i[p]] = qos_mem_bus_pkg::port_idx_t'(p);
            end
        end
    end

    // ----------------------------------------
    // Level FIFOs
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < NL; l++) begin
            if (push_en[l]) begin
                q_req[l][wr_ptr[l]]  <= req_i[push_src[l]];
                q_port[l][wr_ptr[l]] <= push_src[l];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int l = 0; l < NL; l++) begin
                wr_ptr[l] <= '0;
                rd_ptr[l] <= '0;
                count[l]  <= '0;
            end
        end else begin
            for (int l = 0; l < NL; l++) begin
                if (push_en[l]) begin
                    wr_ptr[l] <= ptr_next(wr_ptr[l]);
                end
                if (pop_en[l]) begin
                    rd_ptr[l] <= ptr_next(rd_ptr[l]);
                end
                // Push and pop together leave the count alone
                if (push_en[l] && !pop_en[l]) begin
                    count[l] <= count[l] + 1'b1;
                end else if (!push_en[l] && pop_en[l]) begin
                    count[l] <= count[l] - 1'b1;
                end
            end
        end
    end

    // Head of every level, read straight from storage
    always_comb begin
        for (int l = 0; l < NL; l++) begin
            head.not_empty[l] = (count[l] != '0);
            head.head_req[l]  = q_req[l][rd_ptr[l]];
            head.head_port[l] = q_port[l][rd_ptr[l]];
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        head.pop |-> head.not_empty[head.pop_level]);

    // A full level only leaves full through a pop
    for (genvar l = 0; l < NL; l++) begin : g_full_chk
        a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
            (count[l] == CNT_W'(DEPTH)) && !pop_en[l] |=> count[l] == CNT_W'(DEPTH));
    end

endmodule

// ==== qos_level_arbiter.sv ====
/*
 * Processing part of the wrapper. Selects one level head per cycle by strict
 * priority or round robin, drives the memory request and counts grants.
 */
`include "qos_mem_defines.svh"

module qos_level_arbiter (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  qos_mem_cfg_pkg::arb_policy_e             policy_i,
    qos_head_if.arbiter                              head,
    output logic                                     mem_req_valid_o,
    input  logic                                     mem_req_ready_i,
    output qos_mem_bus_pkg::mem_req_t                mem_req_o,
    output logic                                     grant_o,
    output qos_mem_bus_pkg::port_idx_t               grant_port_o,
    input  logic                                     track_full_i,
    output logic [`QM_NUM_PORTS-1:0][`QM_CNT_W-1:0]  grant_count_o
);

    localparam int NL = `QM_NUM_LEVELS;

    qos_mem_cfg_pkg::qos_level_t pick_lvl;
    qos_mem_cfg_pkg::qos_level_t sel_lvl;
    qos_mem_cfg_pkg::qos_level_t last_lvl_q;
    qos_mem_cfg_pkg::qos_level_t lock_lvl_q;
    logic                        lock_q;
    logic                        xfer;

    // ----------------------------------------
    // Level selection
    // ----------------------------------------

    always_comb begin : proc_pick
        qos_mem_cfg_pkg::qos_level_t rr_lvl;
        pick_lvl = '0;
        rr_lvl   = '0;
        case (policy_i)
            qos_mem_cfg_pkg::ARB_STRICT_PRIO: begin
                // Later hits overwrite, so the top non-empty level wins
                for (int l = 0; l < NL; l++) begin
                    if (head.not_empty[l]) begin
                        pick_lvl = qos_mem_cfg_pkg::qos_level_t'(l);
                    end
                end
            end
            default: begin
                // Scan backwards so the level right after the last grant wins
                for (int i = NL; i >= 1; i--) begin
                    rr_lvl = qos_mem_cfg_pkg::qos_level_t'((int'(last_lvl_q) + i) % NL);
                    if (head.not_empty[rr_lvl]) begin
                        pick_lvl = rr_lvl;
                    end
                end
            end
        endcase
    end

    // A stalled request keeps its level even if a better one fills meanwhile
    assign sel_lvl = lock_q ? lock_lvl_q : pick_lvl;

    // ----------------------------------------
    // Memory request and grant
    // ----------------------------------------

    assign mem_req_valid_o = (|head.not_empty) && !track_full_i;
    assign mem_req_o       = head.head_req[sel_lvl];
    assign xfer            = mem_req_valid_o && mem_req_ready_i;

    assign head.pop        = xfer;
    assign head.pop_level  = sel_lvl;

    assign grant_o         = xfer;
    assign grant_port_o    = head.head_port[sel_lvl];

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
        if (!rst_ni) begin
            // Top level as last grant, so round robin starts at level 0
            last_lvl_q    <= qos_mem_cfg_pkg::qos_level_t'(NL - 1);
            lock_q        <= 1'b0;
            lock_lvl_q    <= '0;
            grant_count_o <= '0;
        end else begin
            lock_q     <= mem_req_valid_o && !mem_req_ready_i;
            lock_lvl_q <= sel_lvl;
            if (xfer) begin
                last_lvl_q                  <= sel_lvl;
                grant_count_o[grant_port_o] <= grant_count_o[grant_port_o] + 1'b1;
            end
        end
    end

    // Offered request holds until the memory takes it
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

// ==== qos_rsp_router.sv ====
/*
 * Output side of the wrapper. Records the source port of every grant in
 * order and steers each in-order memory response back to that port.
 */
`include "qos_mem_defines.svh"

module qos_rsp_router (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        grant_i,
    input  qos_mem_bus_pkg::port_idx_t  grant_port_i,
    output logic                        track_full_o,
    input  logic                        mem_rsp_valid_i,
    input  logic [`QM_DATA_W-1:0]       mem_rsp_rdata_i,
    output logic [`QM_NUM_PORTS-1:0]    rsp_valid_o,
    output logic [`QM_DATA_W-1:0]       rsp_rdata_o
);

    localparam int DEPTH = `QM_TRACK_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    qos_mem_bus_pkg::port_idx_t src_mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;

    assign track_full_o = (count == CNT_W'(DEPTH));

    // ----------------------------------------
    // Source port tracker
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (grant_i) begin
            src_mem[wr_ptr] <= grant_port_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (grant_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (mem_rsp_valid_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (grant_i && !mem_rsp_valid_i) begin
                count <= count + 1'b1;
            end else if (!grant_i && mem_rsp_valid_i) begin
                count <= count - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Response steering
    // ----------------------------------------

    // Single-cycle pulse on the port at the tracker head
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_o <= '0;
        end else begin
            rsp_valid_o <= '0;
            if (mem_rsp_valid_i) begin
                rsp_valid_o[src_mem[rd_ptr]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rsp_valid_i) begin
            rsp_rdata_o <= mem_rsp_rdata_i;
        end
    end

    // Memory only answers requests it has taken
    a_rsp_has_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_valid_i |-> count != '0);

endmodule

// ==== qos_mem_wrapper.sv ====
/*
 * Top level of the two-port QoS memory wrapper. Packs the port signals into
 * request structs and connects the queues, the arbiter and the router.
 */
`include "qos_mem_defines.svh"

module qos_mem_wrapper (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  qos_mem_cfg_pkg::arb_policy_e                    policy_i,
    input  logic [`QM_NUM_PORTS-1:0]                        req_valid_i,
    output logic [`QM_NUM_PORTS-1:0]                        req_ready_o,
    input  logic [`QM_NUM_PORTS-1:0]                        req_write_i,
    input  logic [`QM_NUM_PORTS-1:0][`QM_ADDR_W-1:0]        req_addr_i,
    input  logic [`QM_NUM_PORTS-1:0][`QM_DATA_W-1:0]        req_wdata_i,
    input  qos_mem_cfg_pkg::qos_level_t [`QM_NUM_PORTS-1:0] req_qos_i,
    output logic [`QM_NUM_PORTS-1:0]                        rsp_valid_o,
    output logic [`QM_DATA_W-1:0]                           rsp_rdata_o,
    output logic                                            mem_req_valid_o,
    input  logic                                            mem_req_ready_i,
    output logic                                            mem_req_write_o,
    output logic [`QM_ADDR_W-1:0]                           mem_req_addr_o,
    output logic [`QM_DATA_W-1:0]                           mem_req_wdata_o,
    input  logic                                            mem_rsp_valid_i,
    input  logic [`QM_DATA_W-1:0]                           mem_rsp_rdata_i,
    output logic [`QM_NUM_PORTS-1:0][`QM_CNT_W-1:0]         grant_count_o
);

    qos_mem_bus_pkg::mem_req_t [`QM_NUM_PORTS-1:0] port_req;
    qos_mem_bus_pkg::mem_req_t                     mem_req;
    logic                                          grant;
    qos_mem_bus_pkg::port_idx_t                    grant_port;
    logic                                          track_full;

    always_comb begin
        for (int p = 0; p < `QM_NUM_PORTS; p++) begin
            port_req[p].write = req_write_i[p];
            port_req[p].addr  = req_addr_i[p];
            port_req[p].wdata = req_wdata_i[p];
        end
    end

    assign mem_req_write_o = mem_req.write;
    assign mem_req_addr_o  = mem_req.addr;
    assign mem_req_wdata_o = mem_req.wdata;

    qos_head_if u_head_if ();

    qos_level_queues u_queues (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (port_req),
        .req_qos_i   (req_qos_i),
        .head        (u_head_if.queue)
    );

    qos_level_arbiter u_arbiter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .policy_i        (policy_i),
        .head            (u_head_if.arbiter),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req),
        .grant_o         (grant),
        .grant_port_o    (grant_port),
        .track_full_i    (track_full),
        .grant_count_o   (grant_count_o)
    );

    qos_rsp_router u_router (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .grant_i         (grant),
        .grant_port_i    (grant_port),
        .track_full_o    (track_full),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o)
    );

endmodule

// ==== tb_qos_mem_wrapper.sv ====
/*
 * Self-checking testbench for the QoS memory wrapper. Drives both ports,
 * models a memory that answers in order two cycles late, and checks grant
 * order, response routing and the grant counters with assertions.
 */
`include "qos_mem_defines.svh"

module tb_qos_mem_wrapper;
    timeunit 1ns;
    timeprecision 100ps;

    // Tests take about 200 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                                            clk_i;
    logic                                            rst_ni;
    qos_mem_cfg_pkg::arb_policy_e                    policy;
    logic [`QM_NUM_PORTS-1:0]                        req_valid;
    logic [`QM_NUM_PORTS-1:0]                        req_ready;
    logic [`QM_NUM_PORTS-1:0]                        req_write;
    logic [`QM_NUM_PORTS-1:0][`QM_ADDR_W-1:0]        req_addr;
    logic [`QM_NUM_PORTS-1:0][`QM_DATA_W-1:0]        req_wdata;
    qos_mem_cfg_pkg::qos_level_t [`QM_NUM_PORTS-1:0] req_qos;
    logic [`QM_NUM_PORTS-1:0]                        rsp_valid;
    logic [`QM_DATA_W-1:0]                           rsp_rdata;
    logic                                            mem_req_valid;
    logic                                            mem_ready;
    logic                                            mem_req_write;
    logic [`QM_ADDR_W-1:0]                           mem_req_addr;
    logic [`QM_DATA_W-1:0]                           mem_req_wdata;
    logic                                            mem_rsp_valid = 1'b0;
    logic [`QM_DATA_W-1:0]                           mem_rsp_rdata = '0;
    logic [`QM_NUM_PORTS-1:0][`QM_CNT_W-1:0]         grant_count;

    // Scoreboard and memory model state
    logic [`QM_ADDR_W-1:0] xfer_q [$];
    logic [`QM_ADDR_W-1:0] exp_order [$];
    int                    exp_port_q [$];
    logic [`QM_DATA_W-1:0] exp_data_q [$];
    int                    mem_due_q [$];
    logic [`QM_DATA_W-1:0] mem_data_q [$];
    int                    xfer_cnt [`QM_NUM_PORTS];
    int                    rsp_cnt = 0;
    int                    cycle_cnt = 0;
    logic [31:0]           rng_state = 32'h6032;
    int                    errors = 0;
    int                    mon_errors = 0;
    int                    sva_errors = 0;
    int                    tests_run = 0;
    int                    tests_bad = 0;

    qos_mem_wrapper u_qos_mem_wrapper (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .policy_i        (policy),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .req_write_i     (req_write),
        .req_addr_i      (req_addr),
        .req_wdata_i     (req_wdata),
        .req_qos_i       (req_qos),
        .rsp_valid_o     (rsp_valid),
        .rsp_rdata_o     (rsp_rdata),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_ready),
        .mem_req_write_o (mem_req_write),
        .mem_req_addr_o  (mem_req_addr),
        .mem_req_wdata_o (mem_req_wdata),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_rdata_i (mem_rsp_rdata),
        .grant_count_o   (grant_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Read data of the memory model for one address
    function automatic logic [31:0] mem_value(input logic [`QM_ADDR_W-1:0] addr);
        return lcg(lcg(32'h6032 ^ {16'h0, addr}));
    endfunction

    function automatic logic [15:0] next_rand();
        rng_state = lcg(rng_state);
        return rng_state[31:16];
    endfunction

    // Address layout: port, level, sequence number
    function automatic logic [15:0] make_addr(input int p, input int lvl, input int seq);
        return {4'(p), 4'(lvl), 8'(seq)};
    endfunction

    function automatic int error_total();
        return errors + mon_errors + sva_errors;
    endfunction

    // ----------------------------------------
    // Memory model and response scoreboard
    // ----------------------------------------

    always @(posedge clk_i) begin : mem_model
        int                    p;
        logic [`QM_DATA_W-1:0] exp_data;
        if (rst_ni && (|rsp_valid)) begin
            if (exp_port_q.size() == 0) begin
                $display("A response came back with no request outstanding");
                mon_errors++;
            end else begin
                p        = exp_port_q.pop_front();
                exp_data = exp_data_q.pop_front();
                rsp_cnt++;
                assert (rsp_valid == 2'(1 << p)) else begin
                    $display("** Error: rsp_valid_o = %h, expected %h", rsp_valid, 2'(1 << p));
                    mon_errors++;
                end
                assert (rsp_rdata == exp_data) else begin
                    $display("** Error: rsp_rdata_o = %h, expected %h", rsp_rdata, exp_data);
                    mon_errors++;
                end
            end
        end
        if (rst_ni && mem_req_valid && mem_ready) begin
            p = int'(mem_req_addr[15:12]);
            assert (mem_req_wdata == {mem_req_addr, ~mem_req_addr}) else begin
                $display("** Error: mem_req_wdata_o = %h, expected %h",
                         mem_req_wdata, {mem_req_addr, ~mem_req_addr});
                mon_errors++;
            end
            // Stimulus sets the write flag from the low address bit
            assert (mem_req_write == mem_req_addr[0]) else begin
                $display("** Error: mem_req_write_o = %h, expected %h",
                         mem_req_write, mem_req_addr[0]);
                mon_errors++;
            end
            xfer_q.push_back(mem_req_addr);
            exp_port_q.push_back(p);
            exp_data_q.push_back(mem_value(mem_req_addr));
            mem_due_q.push_back(cycle_cnt + 2);
            mem_data_q.push_back(mem_value(mem_req_addr));
            xfer_cnt[p]++;
        end
        cycle_cnt++;
        #2;
        if (mem_due_q.size() != 0 && mem_due_q[0] == cycle_cnt) begin
            void'(mem_due_q.pop_front());
            mem_rsp_valid = 1'b1;
            mem_rsp_rdata = mem_data_q.pop_front();
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout after %0d cycles, traffic stopped making progress", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    a_port1_yields: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid[0] && req_valid[1] && (req_qos[0] == req_qos[1]) |-> !req_ready[1])
        else begin
            $display("Port 1 was accepted while port 0 asked for the same level");
            sva_errors++;
        end

    a_rsp_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(rsp_valid))
        else begin
            $display("A response pulsed on more than one port");
            sva_errors++;
        end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    task automatic drive_req(input int p, input int lvl, input logic [15:0] addr);
        req_valid[p] = 1'b1;
        req_qos[p]   = qos_mem_cfg_pkg::qos_level_t'(lvl);
        req_addr[p]  = addr;
        req_wdata[p] = {addr, ~addr};
        req_write[p] = addr[0];
    endtask

    task automatic wait_accept(input int p);
        do @(posedge clk_i); while (!req_ready[p]);
        #2;
        req_valid[p] = 1'b0;
    endtask

    task automatic issue(input int p, input int lvl, input logic [15:0] addr);
        drive_req(p, lvl, addr);
        wait_accept(p);
    endtask

    // Let the memory take everything and wait for the last response
    task automatic drain();
        mem_ready = 1'b1;
        do @(negedge clk_i); while (exp_port_q.size() != 0 || mem_req_valid);
        @(posedge clk_i);
        #2;
    endtask

    task automatic check_order(input int base);
        if (xfer_q.size() - base != exp_order.size()) begin
            $display("Memory port carried %0d requests, expected %0d",
                     xfer_q.size() - base, exp_order.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_order.size(); i++) begin
                assert (xfer_q[base + i] == exp_order[i]) else begin
                    $display("** Error: mem_req_addr_o = %h, expected %h",
                             xfer_q[base + i], exp_order[i]);
                    errors++;
                end
            end
        end
        exp_order.delete();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (error_total() == errs_before) begin
            $display("[ok]   %s", name);
        end else begin
            tests_bad++;
            $display("[bad]  %s, %0d errors", name, error_total() - errs_before);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : stimulus
        int          start;
        int          base;
        int          rsp_base;
        logic [15:0] r;
        int          lvls [3];
        rst_ni    = 1'b0;
        policy    = qos_mem_cfg_pkg::ARB_STRICT_PRIO;
        req_valid = '0;
        req_write = '0;
        req_addr  = '0;
        req_wdata = '0;
        req_qos   = '0;
        mem_ready = 1'b0;
        lvls      = '{0, 2, 3};
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        start = error_total();
        assert (!mem_req_valid && req_ready == '0 && rsp_valid == '0 && grant_count == '0)
            else begin
                $display("Wrapper is not idle after reset");
                errors++;
            end
        end_test("reset state", start);

        // Port 1 at level 3 must beat port 0 at level 1
        start = error_total();
        base  = xfer_q.size();
        fork
            issue(0, 1, make_addr(0, 1, 8'h10));
            issue(1, 3, make_addr(1, 3, 8'h11));
        join
        exp_order.push_back(make_addr(1, 3, 8'h11));
        exp_order.push_back(make_addr(0, 1, 8'h10));
        drain();
        check_order(base);
        end_test("strict priority", start);

        start = error_total();
        base  = xfer_q.size();
        mem_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            issue(i % 2, 2, make_addr(i % 2, 2, 8'h20 + i));
            exp_order.push_back(make_addr(i % 2, 2, 8'h20 + i));
        end
        drain();
        check_order(base);
        end_test("order within a level", start);

        // Level 0 fills first, so rotation starts there
        start  = error_total();
        base   = xfer_q.size();
        policy = qos_mem_cfg_pkg::ARB_ROUND_ROBIN;
        mem_ready = 1'b0;
        for (int i = 0; i < 6; i++) begin
            issue(i % 2, lvls[i / 2], make_addr(i % 2, lvls[i / 2], 8'h30 + i));
        end
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 3; j++) begin
                exp_order.push_back(make_addr(k, lvls[j], 8'h30 + j * 2 + k));
            end
        end
        drain();
        check_order(base);
        end_test("round robin", start);

        // Mixed traffic on both ports, memory stalls now and then
        start    = error_total();
        base     = xfer_q.size();
        rsp_base = rsp_cnt;
        for (int i = 0; i < 20; i++) begin
            r         = next_rand();
            mem_ready = (r[1:0] != 2'b00);
            policy    = qos_mem_cfg_pkg::arb_policy_e'(r[6]);
            fork
                issue(0, int'(r[3:2]), make_addr(0, int'(r[3:2]), 8'h40 + i));
                issue(1, int'(r[5:4]), make_addr(1, int'(r[5:4]), 8'h40 + i));
                begin
                    repeat (3) @(posedge clk_i);
                    #2;
                    mem_ready = 1'b1;
                end
            join
        end
        drain();
        if (rsp_cnt - rsp_base != xfer_q.size() - base) begin
            $display("Got %0d responses for %0d memory requests",
                     rsp_cnt - rsp_base, xfer_q.size() - base);
            errors++;
        end
        end_test("response routing", start);

        // Fifth request at a full level must wait
        start  = error_total();
        base   = xfer_q.size();
        policy = qos_mem_cfg_pkg::ARB_STRICT_PRIO;
        mem_ready = 1'b0;
        for (int i = 0; i < 5; i++) begin
            exp_order.push_back(make_addr(0, 1, 8'h50 + i));
        end
        for (int i = 0; i < 4; i++) begin
            issue(0, 1, make_addr(0, 1, 8'h50 + i));
        end
        drive_req(0, 1, make_addr(0, 1, 8'h54));
        repeat (3) begin
            @(posedge clk_i);
            assert (req_ready == 2'b00) else begin
                $display("** Error: req_ready_o = %h, expected %h", req_ready, 2'b00);
                errors++;
            end
        end
        #2;
        mem_ready = 1'b1;
        wait_accept(0);
        drain();
        check_order(base);
        end_test("back-pressure", start);

        start = error_total();
        for (int p = 0; p < `QM_NUM_PORTS; p++) begin
            assert (grant_count[p] == 16'(xfer_cnt[p])) else begin
                $display("** Error: grant_count_o[%0d] = %h, expected %h",
                         p, grant_count[p], 16'(xfer_cnt[p]));
                errors++;
            end
        end
        end_test("grant counters", start);

        $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, error_total());
        if (error_total() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
qos_mem_cfg_pkg.sv
qos_mem_bus_pkg.sv
qos_head_if.sv
qos_level_queues.sv
qos_level_arbiter.sv
qos_rsp_router.sv
qos_mem_wrapper.sv
tb_qos_mem_wrapper.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_qos_mem_wrapper
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
